// File: glue_config.svh
// Build-time constants for the bus glue
// Divider ratios, wait counts and the address map, shared by RTL and testbench
`ifndef GLUE_CONFIG_SVH
`define GLUE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////
// Clock dividers, all in clk40 cycles
////////////////////////////////////////////////////////////////////////

// Full CIA clock period, keep it even
`define CIA_DIV 10
// Tick square wave half periods
`define TICK60_HALF 50
`define TICK50_HALF 60

////////////////////////////////////////////////////////////////////////
// Wait states before tackN, at least 1
////////////////////////////////////////////////////////////////////////

`define ROM_WAIT 3
`define CHIP_WAIT 5

////////////////////////////////////////////////////////////////////////
// Address map, byte addresses
////////////////////////////////////////////////////////////////////////

`define ROM_BASE 32'h00F8_0000
// First address above the overlay window, also the ROM size
`define ROM_OVL_TOP 32'h0008_0000
`define CHIP_TOP 32'h0020_0000
// Upper address bits 31:16 of the CIA space
`define CIA_PAGE 16'h00BF
// Upper address bits 31:12 of the custom registers
`define REG_PAGE 20'h00DFF

`endif

// File: source/gluePkg.sv
// Types shared by the bus glue modules and the testbench
// Import with a wildcard in the module header

package gluePkg;

    ////////////////////////////////////////////////////////////////////////
    // Bus vectors
    ////////////////////////////////////////////////////////////////////////

    // CPU address without bit 0
    typedef logic [31:1] addrT;

    // Wait state down counter
    typedef logic [3:0] waitCountT;

    // CIA clock divider position
    typedef logic [5:0] ciaCountT;

    // Tick half period position
    typedef logic [7:0] tickCountT;

    ////////////////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////////////////

    // Decoded target of a transfer
    typedef enum logic [2:0] {
        spaceNone = 3'd0,
        spaceRom  = 3'd1,
        spaceCia  = 3'd2,
        spaceChip = 3'd3,
        spaceReg  = 3'd4
    } spaceT;

    // Transfer sequencer states
    typedef enum logic [2:0] {
        stIdle   = 3'd0,
        stDecode = 3'd1,
        stWait   = 3'd2,
        stCia    = 3'd3,
        stAck    = 3'd4
    } busStateT;

endpackage

// File: source/addressDecode.sv
// Address decoder for CPU transfers
// Latches the target space on decodeStrobe and holds the selects until transferDone
`timescale 1ns/10ps
`include "glue_config.svh"

module addressDecode import gluePkg::*; (
    input  logic  clk40,
    input  logic  reset,
    input  logic  decodeStrobe,
    input  logic  transferDone,
    input  logic  ovl,
    input  addrT  addr,
    output spaceT space,
    output logic  romEnN,
    output logic  ciaCs0N,
    output logic  ciaCs1N,
    output logic  ramSpaceN,
    output logic  regSpaceN,
    output logic  bufEnN,
    output logic  portSize
);

    // Pin order {romEnN, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN, bufEnN, portSize}
    localparam logic [6:0] idlePins = 7'b111_1110;

    logic [6:0] pins;

    ////////////////////////////////////////////////////////////////////////
    // Decode helpers
    ////////////////////////////////////////////////////////////////////////

    // Overlay first, so low memory reads ROM while ovl is high
    function automatic spaceT classify(input addrT a, input logic overlay);
        logic [31:0] byteAddr;
        byteAddr = {a, 1'b0};
        if (overlay && byteAddr < `ROM_OVL_TOP)
            return spaceRom;
        if (byteAddr >= `ROM_BASE && byteAddr < `ROM_BASE + `ROM_OVL_TOP)
            return spaceRom;
        if (byteAddr < `CHIP_TOP)
            return spaceChip;
        if (byteAddr[31:16] == `CIA_PAGE)
            return spaceCia;
        if (byteAddr[31:12] == `REG_PAGE)
            return spaceReg;
        return spaceNone;
    endfunction

    // Pin levels for one space, with the CIA chip select bits
    function automatic logic [6:0] pinsFor(input spaceT s, input logic a12, input logic a13);
        logic [6:0] p;
        p = idlePins;
        case (s)
            spaceRom: p[6] = 1'b0;
            spaceCia: begin
                // Each CIA answers on its own low address bit
                p[5] = a12;
                p[4] = a13;
                p[0] = 1'b1;
            end
            spaceChip: begin
                p[3] = 1'b0;
                p[1] = 1'b0;
            end
            spaceReg: begin
                p[2] = 1'b0;
                p[1] = 1'b0;
                p[0] = 1'b1;
            end
            default: p = idlePins;
        endcase
        return p;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Space and pin registers
    ////////////////////////////////////////////////////////////////////////

    // Pins load together with the space so the selects are valid from the start edge
    always_ff @(posedge clk40) begin
        if (reset) begin
            space <= spaceNone;
            pins  <= idlePins;
        end else if (decodeStrobe) begin
            space <= classify(addr, ovl);
            pins  <= pinsFor(classify(addr, ovl), addr[12], addr[13]);
        end else if (transferDone) begin
            space <= spaceNone;
            pins  <= idlePins;
        end
    end

    assign romEnN    = pins[6];
    assign ciaCs0N   = pins[5];
    assign ciaCs1N   = pins[4];
    assign ramSpaceN = pins[3];
    assign regSpaceN = pins[2];
    assign bufEnN    = pins[1];
    assign portSize  = pins[0];

endmodule

// File: source/ciaTimer.sv
// CIA clock generator
// Divides clk40 by CIA_DIV and flags the last cycle of each CIA clock period
`timescale 1ns/10ps
`include "glue_config.svh"

module ciaTimer import gluePkg::*; (
    input  logic clk40,
    input  logic reset,
    output logic ciaClk,
    output logic ciaEnable
);

    // Last count of the period and first count of the high phase
    localparam ciaCountT lastCount = ciaCountT'(`CIA_DIV - 1);
    localparam ciaCountT highStart = ciaCountT'(`CIA_DIV / 2);

    ciaCountT count;
    ciaCountT nextCount;

    ////////////////////////////////////////////////////////////////////////
    // Divider
    ////////////////////////////////////////////////////////////////////////

    // Wrap at the end of the period
    always_comb begin
        if (count == lastCount)
            nextCount = '0;
        else
            nextCount = count + 1'b1;
    end

    // ciaClk follows the count it is registered with, low half first
    always_ff @(posedge clk40) begin
        if (reset) begin
            count  <= '0;
            ciaClk <= 1'b0;
        end else begin
            count  <= nextCount;
            ciaClk <= (nextCount >= highStart);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Access strobe
    ////////////////////////////////////////////////////////////////////////

    // Last high cycle, the next edge drops ciaClk
    // A CIA access acked here ends with the falling CIA edge
    assign ciaEnable = (count == lastCount);

endmodule

// File: source/tickTimer.sv
// Time base ticks for the CIA event counters
// Two free-running square waves toggling every TICK60_HALF and TICK50_HALF cycles
`timescale 1ns/10ps
`include "glue_config.svh"

module tickTimer import gluePkg::*; (
    input  logic clk40,
    input  logic reset,
    output logic tick60,
    output logic tick50
);

    // Index 0 is the 60 Hz style tick, index 1 the 50 Hz style tick
    localparam tickCountT lastCount [2] = '{
        tickCountT'(`TICK60_HALF - 1),
        tickCountT'(`TICK50_HALF - 1)
    };

    logic [1:0] tickLevel;

    ////////////////////////////////////////////////////////////////////////
    // Half period counters
    ////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin : gTick
        tickCountT count;
        logic      level;

        // Toggle on the last count of each half period
        always_ff @(posedge clk40) begin
            if (reset) begin
                count <= '0;
                level <= 1'b0;
            end else if (count == lastCount[i]) begin
                count <= '0;
                level <= ~level;
            end else begin
                count <= count + 1'b1;
            end
        end

        assign tickLevel[i] = level;
    end

    assign tick60 = tickLevel[0];
    assign tick50 = tickLevel[1];

endmodule

// File: source/transferAck.sv
// Transfer sequencer for the bus glue
// Starts a decode on tsN, inserts the wait states of the target space
// and answers with a single-cycle tackN
`timescale 1ns/10ps
`include "glue_config.svh"

module transferAck import gluePkg::*; (
    input  logic  clk40,
    input  logic  reset,
    input  logic  tsN,
    input  spaceT space,
    input  logic  ciaEnable,
    output logic  decodeStrobe,
    output logic  transferDone,
    output logic  tackN
);

    // Wait loads, each counts down to 1 before the ack cycle
    localparam waitCountT romWait  = waitCountT'(`ROM_WAIT);
    localparam waitCountT chipWait = waitCountT'(`CHIP_WAIT);

    busStateT  state;
    busStateT  nextState;
    waitCountT waitCount;
    waitCountT nextWait;

    ////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState    = state;
        nextWait     = waitCount;
        decodeStrobe = 1'b0;
        transferDone = 1'b0;

        case (state)
            // tsN is a level, sampled only here
            stIdle: begin
                if (!tsN) begin
                    decodeStrobe = 1'b1;
                    nextState    = stDecode;
                end
            end

            // Space was latched on the start edge
            stDecode: begin
                case (space)
                    spaceRom: begin
                        nextWait  = romWait;
                        nextState = stWait;
                    end
                    spaceChip, spaceReg: begin
                        nextWait  = chipWait;
                        nextState = stWait;
                    end
                    spaceCia: nextState = stCia;
                    default: begin
                        // Unmapped, drop it without an ack
                        transferDone = 1'b1;
                        nextState    = stIdle;
                    end
                endcase
            end

            stWait: begin
                if (waitCount == waitCountT'(1))
                    nextState = stAck;
                else
                    nextWait = waitCount - 1'b1;
            end

            // Hold until the CIA clock is about to fall
            stCia: begin
                if (ciaEnable)
                    nextState = stAck;
            end

            // tackN low this cycle, decoder clears on the closing edge
            stAck: begin
                transferDone = 1'b1;
                nextState    = stIdle;
            end

            default: nextState = stIdle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // State registers
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk40) begin
        if (reset) begin
            state     <= stIdle;
            waitCount <= '0;
            tackN     <= 1'b1;
        end else begin
            state     <= nextState;
            waitCount <= nextWait;
            // Registered pin, low exactly while in stAck
            tackN     <= (nextState != stAck);
        end
    end

endmodule

// File: source/glueTop.sv
// Bus glue top level
// Connects the address decoder, the transfer sequencer and the two clock dividers
`timescale 1ns/10ps

module glueTop import gluePkg::*; (
    input  logic clk40,
    input  logic reset,
    input  logic tsN,
    input  logic ovl,
    input  addrT addr,
    output logic tackN,
    output logic romEnN,
    output logic ciaCs0N,
    output logic ciaCs1N,
    output logic ramSpaceN,
    output logic regSpaceN,
    output logic bufEnN,
    output logic portSize,
    output logic ciaClk,
    output logic tick60,
    output logic tick50
);

    // Sequencer to decoder handshake
    logic  decodeStrobe;
    logic  transferDone;
    spaceT space;
    // CIA access window
    logic  ciaEnable;

    ////////////////////////////////////////////////////////////////////////
    // Transfer path
    ////////////////////////////////////////////////////////////////////////

    transferAck uTransferAck (
        .clk40        (clk40),
        .reset        (reset),
        .tsN          (tsN),
        .space        (space),
        .ciaEnable    (ciaEnable),
        .decodeStrobe (decodeStrobe),
        .transferDone (transferDone),
        .tackN        (tackN)
    );

    addressDecode uAddressDecode (
        .clk40        (clk40),
        .reset        (reset),
        .decodeStrobe (decodeStrobe),
        .transferDone (transferDone),
        .ovl          (ovl),
        .addr         (addr),
        .space        (space),
        .romEnN       (romEnN),
        .ciaCs0N      (ciaCs0N),
        .ciaCs1N      (ciaCs1N),
        .ramSpaceN    (ramSpaceN),
        .regSpaceN    (regSpaceN),
        .bufEnN       (bufEnN),
        .portSize     (portSize)
    );

    ////////////////////////////////////////////////////////////////////////
    // Clock dividers
    ////////////////////////////////////////////////////////////////////////

    ciaTimer uCiaTimer (
        .clk40     (clk40),
        .reset     (reset),
        .ciaClk    (ciaClk),
        .ciaEnable (ciaEnable)
    );

    // Free running, not tied to any transfer
    tickTimer uTickTimer (
        .clk40  (clk40),
        .reset  (reset),
        .tick60 (tick60),
        .tick50 (tick50)
    );

endmodule

// File: tests/glue_chk.sv
// Concurrent checks on the transfer sequencer
// Attached to every transferAck instance with bind
`timescale 1ns/10ps

module glueChk import gluePkg::*; (
    input logic     clk40,
    input logic     reset,
    input busStateT state,
    input logic     tackN,
    input logic     decodeStrobe
);

    // Ack is a single-cycle pulse
    ackPulse: assert property (@(posedge clk40) disable iff (reset) !tackN |=> tackN)
        else $error("tackN low for two consecutive cycles");

    // Registered with the state, so both agree on every edge
    ackState: assert property (@(posedge clk40) disable iff (reset) !tackN |-> state == stAck)
        else $error("tackN low outside stAck");

    // Transfers start only from idle
    strobeIdle: assert property (@(posedge clk40) disable iff (reset)
        decodeStrobe |-> state == stIdle)
        else $error("decodeStrobe outside stIdle");

    resetAck: assert property (@(posedge clk40) reset |=> tackN)
        else $error("tackN not high after a reset edge");

endmodule

bind transferAck glueChk uGlueChk (
    .clk40        (clk40),
    .reset        (reset),
    .state        (state),
    .tackN        (tackN),
    .decodeStrobe (decodeStrobe)
);

// File: tests/glueTb.sv
// Testbench for the bus glue top level
// Runs transfers into every space, checks the pins cycle by cycle against a reference
// decode, then measures the tick half periods
`timescale 1ns/10ps
`include "glue_config.svh"

module glueTb import gluePkg::*; ();

    localparam int resetCycles = 3;
    localparam int ackLimit    = `CIA_DIV + `CHIP_WAIT + 4;
    localparam int cycleLimit  = 40 * ackLimit + 4 * `TICK50_HALF * 2 + resetCycles;
    // Post-reset levels of {romEnN, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN, bufEnN, portSize}
    localparam logic [6:0] idlePins = 7'b111_1110;

    typedef struct packed {
        spaceT      space;
        logic [6:0] pins;
        logic [3:0] waitCycles;
    } refT;

    logic clk40 = 1'b0;
    logic reset, tsN, ovl;
    addrT addr;
    logic tackN, romEnN, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN, bufEnN, portSize;
    logic ciaClk, tick60, tick50;

    // Expected {tackN, pins, ciaClk, tick60, tick50}, only masked bits are compared
    logic [10:0] expVec, expMask;
    logic        armed;
    string       label;
    int          edgeCount;
    int          cycleCount;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          passed = 0;
    int          failed = 0;
    logic [31:0] seed = 32'h54c3_9e6f;

    glueTop dut (.*);

    always #4 clk40 = ~clk40;

    // Edges since reset release, the CIA divider phase follows it
    always @(posedge clk40) begin
        if (reset)
            edgeCount <= 0;
        else
            edgeCount <= edgeCount + 1;
    end

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Expected space, pin levels and wait states for one byte address
    function automatic refT refDecode(input logic [31:0] a, input logic overlay);
        refT r;
        if (overlay && a < `ROM_OVL_TOP)
            r.space = spaceRom;
        else if (a >= `ROM_BASE && (a - `ROM_BASE) < `ROM_OVL_TOP)
            r.space = spaceRom;
        else if (a < `CHIP_TOP)
            r.space = spaceChip;
        else if (a[31:16] == `CIA_PAGE)
            r.space = spaceCia;
        else if (a[31:12] == `REG_PAGE)
            r.space = spaceReg;
        else
            r.space = spaceNone;
        r.pins[6] = (r.space != spaceRom);
        r.pins[5] = !(r.space == spaceCia && !a[12]);
        r.pins[4] = !(r.space == spaceCia && !a[13]);
        r.pins[3] = (r.space != spaceChip);
        r.pins[2] = (r.space != spaceReg);
        r.pins[1] = !(r.space == spaceChip || r.space == spaceReg);
        r.pins[0] = (r.space == spaceCia || r.space == spaceReg);
        if (r.space == spaceRom)
            r.waitCycles = `ROM_WAIT;
        else if (r.space == spaceChip || r.space == spaceReg)
            r.waitCycles = `CHIP_WAIT;
        else
            r.waitCycles = 0;
        return r;
    endfunction

    // ciaClk after edge n, low half of the period first
    function automatic logic ciaLevel(input int n);
        return (n % `CIA_DIV) >= (`CIA_DIV / 2);
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////////////////////////////////////

    // Mid-cycle sample, all outputs settled
    always @(negedge clk40) begin
        logic [10:0] actual;
        actual = {tackN, romEnN, ciaCs0N, ciaCs1N, ramSpaceN, regSpaceN, bufEnN, portSize,
                  ciaClk, tick60, tick50};
        if (armed && ((actual ^ expVec) & expMask) !== 11'b0) begin
            $display("** Error %s: expected %b, actual %b", label, expVec & expMask,
                     actual & expMask);
            testErrors++;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////

    // One transfer, expectations set per cycle after each edge from E on
    task automatic runTransfer(input string name, input logic [31:0] a, input logic overlay);
        refT r;
        int  e;
        int  ackAt;
        bit  acked;
        r = refDecode(a, overlay);
        @(posedge clk40);
        #1;
        addr  = a[31:1];
        ovl   = overlay;
        tsN   = 1'b0;
        label = name;
        @(posedge clk40);
        #1;
        tsN   = 1'b1;
        e     = edgeCount;
        acked = 1'b0;
        // CIA ack lands on the next falling ciaClk once stCia is reached
        if (r.space == spaceCia) begin
            ackAt = 2;
            while ((e + ackAt) % `CIA_DIV != 0)
                ackAt++;
        end else if (r.space == spaceNone) begin
            ackAt = `CHIP_WAIT + 2;
        end else begin
            ackAt = 1 + r.waitCycles;
        end
        armed = 1'b1;
        for (int k = 0; k <= ackAt + 1; k++) begin
            if (k > 0) begin
                @(posedge clk40);
                #1;
            end
            if (!tackN)
                acked = 1'b1;
            expMask = 11'b111_1111_1100;
            if (r.space != spaceNone && k <= ackAt)
                expVec = {k != ackAt, r.pins, ciaLevel(e + k), 2'b00};
            else
                expVec = {1'b1, idlePins, ciaLevel(e + k), 2'b00};
        end
        @(posedge clk40);
        #1;
        armed = 1'b0;
        if (r.space != spaceNone && !acked) begin
            $display("Error %s: tackN never went low for a mapped transfer", name);
            testErrors++;
        end
    endtask

    // Toggle spacing of both ticks over several periods
    task automatic measureTicks();
        logic prev60, prev50;
        int   last60, last50, n60, n50;
        last60 = -1;
        last50 = -1;
        n60    = 0;
        n50    = 0;
        @(negedge clk40);
        prev60 = tick60;
        prev50 = tick50;
        for (int c = 1; c < 4 * `TICK50_HALF * 2 && n50 < 5; c++) begin
            @(negedge clk40);
            if (tick60 != prev60) begin
                if (last60 >= 0 && c - last60 != `TICK60_HALF) begin
                    $display("** Error ticks: tick60 half period expected %0d, actual %0d",
                             `TICK60_HALF, c - last60);
                    testErrors++;
                end
                last60 = c;
                n60++;
            end
            if (tick50 != prev50) begin
                if (last50 >= 0 && c - last50 != `TICK50_HALF) begin
                    $display("** Error ticks: tick50 half period expected %0d, actual %0d",
                             `TICK50_HALF, c - last50);
                    testErrors++;
                end
                last50 = c;
                n50++;
            end
            prev60 = tick60;
            prev50 = tick50;
        end
        if (n60 < 3 || n50 < 3) begin
            $display("Error ticks: too few tick edges seen, %0d and %0d", n60, n50);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d errors", name, testErrors);
            failed++;
        end
        totalErrors += testErrors;
        testErrors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] a;
        reset   = 1'b1;
        tsN     = 1'b1;
        ovl     = 1'b0;
        addr    = '0;
        label   = "reset";
        expVec  = {1'b1, idlePins, 3'b000};
        expMask = '1;
        armed   = 1'b1;
        repeat (resetCycles) @(posedge clk40);
        #1;
        reset = 1'b0;
        // Also covers the first cycle out of reset
        repeat (2) @(posedge clk40);
        #1;
        armed = 1'b0;
        finishTest("reset");

        for (int i = 0; i < 6; i++) begin
            seed = lcgNext(seed);
            runTransfer($sformatf("rom #%0d", i), (`ROM_BASE + (seed % `ROM_OVL_TOP)) & ~32'h1,
                        1'b0);
        end
        // Same low address with and without the overlay
        for (int i = 0; i < 4; i++) begin
            seed = lcgNext(seed);
            a = (seed % `ROM_OVL_TOP) & ~32'h1;
            runTransfer($sformatf("overlay #%0d", i), a, 1'b1);
            runTransfer($sformatf("chip no overlay #%0d", i), a, 1'b0);
        end
        finishTest("rom and overlay");

        for (int i = 0; i < 8; i++) begin
            seed = lcgNext(seed);
            a = {`CIA_PAGE, seed[31:17], 1'b0};
            a[12] = i[0];
            a[13] = i[1];
            runTransfer($sformatf("cia #%0d", i), a, 1'b0);
        end
        finishTest("cia");

        for (int i = 0; i < 6; i++) begin
            seed = lcgNext(seed);
            runTransfer($sformatf("chip #%0d", i), (seed % `CHIP_TOP) & ~32'h1, 1'b0);
            runTransfer($sformatf("reg #%0d", i), {`REG_PAGE, seed[27:17], 1'b0}, 1'b0);
        end
        finishTest("chip and registers");

        // Gap between the CIA page and the custom registers, followed by a normal ROM access
        for (int i = 0; i < 3; i++) begin
            seed = lcgNext(seed);
            runTransfer($sformatf("unmapped #%0d", i), {12'h00C, seed[19:1], 1'b0}, 1'b0);
            runTransfer($sformatf("rom after unmapped #%0d", i), `ROM_BASE | {13'h0, seed[18:1],
                        1'b0}, 1'b0);
        end
        finishTest("unmapped");

        measureTicks();
        finishTest("ticks");

        $display("Tests: %0d ok, %0d failing, %0d errors", passed, failed, totalErrors);
        if (failed == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Run length guard
    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk40);
            cycleCount++;
        end
        $display("Timeout: no result after %0d clock cycles", cycleLimit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
source/gluePkg.sv
source/addressDecode.sv
source/ciaTimer.sv
source/tickTimer.sv
source/transferAck.sv
source/glueTop.sv
tests/glue_chk.sv
tests/glueTb.sv
